//--- common/router_pkg.sv
package router_pkg;

  // Router geometry
  localparam int num_ports = 5;

  // Flit field widths
  localparam int flit_w = 64;
  localparam int hop_w = 4;
  localparam int src_w = 8;
  localparam int payload_w = 32;

  // Encodings of the direction bits in the flit header
  localparam logic west_to_east = 1'b1;
  localparam logic north_to_south = 1'b0;

  // Port numbering, shared by inputs and outputs
  typedef enum logic [2:0] {
    cw  = 3'd0,
    ccw = 3'd1,
    pe  = 3'd2,
    ns  = 3'd3,
    sn  = 3'd4
  } port_e;

  // One bit per port, indexed by port_e
  typedef logic [num_ports-1:0] port_mask_t;

  // Header view of a flit, MSB first
  typedef struct packed {
    logic                 vc;
    logic                 ns_dir;
    logic                 ew_dir;
    logic [4:0]           reserved;
    logic [hop_w-1:0]     y_hop;
    logic [hop_w-1:0]     x_hop;
    logic [src_w-1:0]     y_src;
    logic [src_w-1:0]     x_src;
    logic [payload_w-1:0] payload;
  } flit_hdr_t;

  // Buffers and the crossbar move the raw word, routing looks at the header
  typedef union packed {
    logic [flit_w-1:0] raw;
    flit_hdr_t         hdr;
  } flit_u;

endpackage

//--- common/port_req_if.sv
`timescale 1ns/1ps

// Request path from one input buffer to the switch allocator
interface port_req_if;
  import router_pkg::*;

  logic       valid;
  flit_u      flit;
  port_mask_t req;
  logic       grant;

  modport input_port (
    output valid,
    output flit,
    output req,
    input  grant
  );

  modport allocator (
    input  valid,
    input  flit,
    input  req,
    output grant
  );

endinterface

//--- hdl/input_port.sv
`timescale 1ns/1ps

module input_port (
  input  logic              clk,
  input  logic              reset,
  input  logic              send,
  input  router_pkg::flit_u data,
  output logic              ready,
  port_req_if.input_port    req_port
);
  import router_pkg::*;

  logic       valid_q;
  flit_u      flit_q;
  port_mask_t route;

  // The buffer holds a single flit, so upstream may send only while it is empty
  assign ready = !valid_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (send && ready) begin
      valid_q <= 1'b1;
    end else if (req_port.grant) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (send && ready) begin
      flit_q <= data;
    end
  end

  // Dimension order routing finishes X on the ring, then Y on the column, then ejects
  always_comb begin
    route = '0;
    if (flit_q.hdr.x_hop != '0) begin
      if (flit_q.hdr.ew_dir == west_to_east) begin
        route[cw] = 1'b1;
      end else begin
        route[ccw] = 1'b1;
      end
    end else if (flit_q.hdr.y_hop != '0) begin
      if (flit_q.hdr.ns_dir == north_to_south) begin
        route[ns] = 1'b1;
      end else begin
        route[sn] = 1'b1;
      end
    end else begin
      route[pe] = 1'b1;
    end
  end

  assign req_port.valid = valid_q;
  assign req_port.flit  = flit_q;
  assign req_port.req   = valid_q ? route : '0;

  // A grant empties the buffer and so never lasts two cycles
  a_grant_pulse: assert property (@(posedge clk) disable iff (reset)
    req_port.grant |=> !req_port.grant);

endmodule

//--- switch/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator (
  input  logic                   clk,
  input  logic                   reset,
  port_req_if.allocator          req_ports [router_pkg::num_ports],
  input  router_pkg::port_mask_t out_free,
  output router_pkg::port_mask_t out_load,
  output router_pkg::flit_u      out_flit [router_pkg::num_ports]
);
  import router_pkg::*;

  // Outputs each input requests and outputs that granted it
  port_mask_t req_mat  [num_ports];
  port_mask_t grant_to [num_ports];
  flit_u      in_flit  [num_ports];

  // Round-robin pointer and search result of each output
  logic [2:0] ptr      [num_ports];
  logic [2:0] win_idx  [num_ports];
  port_mask_t win_found;

  function automatic logic [2:0] next_port(input logic [2:0] idx);
    return (idx == 3'(num_ports - 1)) ? 3'd0 : idx + 3'd1;
  endfunction

  genvar i;
  generate
    for (i = 0; i < num_ports; i++) begin : g_in
      assign req_mat[i] = req_ports[i].req;
      assign in_flit[i] = req_ports[i].flit;
      assign req_ports[i].grant = |grant_to[i];

      // A grant only goes to an input that holds a flit
      a_grant_req: assert property (@(posedge clk) disable iff (reset)
        req_ports[i].grant |-> req_ports[i].valid);

      // No input is taken by two outputs in the same cycle
      a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_to[i]));
    end
  endgenerate

  // Search starts at the pointer and wraps once around all inputs
  always_comb begin
    logic [2:0] cand;
    for (int o = 0; o < num_ports; o++) begin
      cand = ptr[o];
      win_idx[o] = ptr[o];
      win_found[o] = 1'b0;
      for (int k = 0; k < num_ports; k++) begin
        if (!win_found[o] && req_mat[cand][o]) begin
          win_found[o] = 1'b1;
          win_idx[o] = cand;
        end
        cand = next_port(cand);
      end
    end
  end

  // A winner moves only when its output register can take the flit
  always_comb begin
    for (int n = 0; n < num_ports; n++) begin
      grant_to[n] = '0;
    end
    for (int o = 0; o < num_ports; o++) begin
      out_load[o] = win_found[o] && out_free[o];
      out_flit[o] = in_flit[win_idx[o]];
      if (out_load[o]) begin
        grant_to[win_idx[o]][o] = 1'b1;
      end
    end
  end

  // The input after the winner gets first chance next time
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int o = 0; o < num_ports; o++) begin
        ptr[o] <= 3'(cw);
      end
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        if (out_load[o]) begin
          ptr[o] <= next_port(win_idx[o]);
        end
      end
    end
  end

endmodule

//--- switch/output_stage.sv
`timescale 1ns/1ps

module output_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  router_pkg::port_mask_t out_load,
  input  router_pkg::flit_u      out_flit [router_pkg::num_ports],
  output router_pkg::port_mask_t out_free,
  output logic                   send [router_pkg::num_ports],
  output router_pkg::flit_u      data [router_pkg::num_ports],
  input  logic                   ready [router_pkg::num_ports]
);
  import router_pkg::*;

  genvar o;
  generate
    for (o = 0; o < num_ports; o++) begin : g_out
      logic  full_q;
      flit_u flit_q;
      flit_u flit_next;

      // Leaving on a ring port uses up one X hop, on a column port one Y hop
      always_comb begin
        flit_next = out_flit[o];
        if (o == int'(cw) || o == int'(ccw)) begin
          flit_next.hdr.x_hop = out_flit[o].hdr.x_hop - 1'b1;
        end else if (o == int'(ns) || o == int'(sn)) begin
          flit_next.hdr.y_hop = out_flit[o].hdr.y_hop - 1'b1;
        end
      end

      // A load in the same cycle as a departure refills the register
      always_ff @(posedge clk) begin
        if (reset) begin
          full_q <= 1'b0;
        end else if (out_load[o]) begin
          full_q <= 1'b1;
        end else if (ready[o]) begin
          full_q <= 1'b0;
        end
      end

      always_ff @(posedge clk) begin
        if (out_load[o]) begin
          flit_q <= flit_next;
        end
      end

      assign out_free[o] = !full_q || ready[o];
      assign send[o] = full_q;
      assign data[o] = flit_q;

      // A stalled flit stays put until downstream takes it
      a_hold: assert property (@(posedge clk) disable iff (reset)
        send[o] && !ready[o] |=> send[o] && $stable(data[o]));
    end
  endgenerate

endmodule

//--- hdl/router_top.sv
`timescale 1ns/1ps

module router_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_send  [router_pkg::num_ports],
  input  logic [router_pkg::flit_w-1:0] in_data [router_pkg::num_ports],
  output logic                        in_ready [router_pkg::num_ports],
  output logic                        out_send [router_pkg::num_ports],
  output logic [router_pkg::flit_w-1:0] out_data [router_pkg::num_ports],
  input  logic                        out_ready [router_pkg::num_ports]
);
  import router_pkg::*;

  port_mask_t out_load;
  port_mask_t out_free;
  flit_u      xbar_flit [num_ports];
  flit_u      out_word  [num_ports];

  port_req_if req_if [num_ports] ();

  // All five inputs share the same buffer and route logic
  genvar i;
  generate
    for (i = 0; i < num_ports; i++) begin : g_port
      input_port input_port_i (
        .clk      (clk),
        .reset    (reset),
        .send     (in_send[i]),
        .data     (in_data[i]),
        .ready    (in_ready[i]),
        .req_port (req_if[i])
      );

      assign out_data[i] = out_word[i].raw;
    end
  endgenerate

  switch_allocator switch_allocator_i (
    .clk       (clk),
    .reset     (reset),
    .req_ports (req_if),
    .out_free  (out_free),
    .out_load  (out_load),
    .out_flit  (xbar_flit)
  );

  output_stage output_stage_i (
    .clk      (clk),
    .reset    (reset),
    .out_load (out_load),
    .out_flit (xbar_flit),
    .out_free (out_free),
    .send     (out_send),
    .data     (out_word),
    .ready    (out_ready)
  );

endmodule

//--- bench/router_tb.sv
`timescale 1ns/1ps

module router_tb;
  import router_pkg::*;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic              in_send [num_ports] = '{default: 1'b0};
  logic [flit_w-1:0] in_data [num_ports] = '{default: '0};
  logic              in_ready [num_ports];
  logic              out_send [num_ports];
  logic [flit_w-1:0] out_data [num_ports];
  logic              out_ready [num_ports] = '{default: 1'b1};

  // Records from the stimulus file, in file order
  byte               rec_kind  [$];
  int                rec_port  [$];
  logic [flit_w-1:0] rec_value [$];
  int                rec_next = 0;

  // Flits still to be sent on each input, and flits still expected on each output
  logic [flit_w-1:0] send_q [num_ports][$];
  logic [flit_w-1:0] exp_q  [num_ports][$];

  logic              next_send  [num_ports];
  logic [flit_w-1:0] next_data  [num_ports];
  logic              next_ready [num_ports];
  logic              stalled    [num_ports];
  logic [flit_w-1:0] held_data  [num_ports];
  logic              search_mode = 1'b0;
  int                rand_left = 0;
  logic [31:0]       lfsr = 32'h1f23d08b;
  int                cycle_count = 0;
  int                cycle_limit = 0;

  always #50 clk = ~clk;

  router_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_send   (in_send),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_send  (out_send),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic string port_name(input int p);
    case (p)
      0: return "cw";
      1: return "ccw";
      2: return "pe";
      3: return "ns";
      default: return "sn";
    endcase
  endfunction

  function automatic int port_index(input string name);
    for (int p = 0; p < num_ports; p++) begin
      if (name == port_name(p)) begin
        return p;
      end
    end
    return -1;
  endfunction

  function automatic int leftover_count();
    int total;
    total = 0;
    for (int p = 0; p < num_ports; p++) begin
      total += exp_q[p].size();
    end
    return total;
  endfunction

  // Nothing queued, nothing being sent and no flit held anywhere in the router
  function automatic logic router_idle();
    for (int p = 0; p < num_ports; p++) begin
      if (send_q[p].size() != 0 || in_send[p] || !in_ready[p] || out_send[p]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [flit_w-1:0] got,
                               input logic [flit_w-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic report_leftovers();
    for (int p = 0; p < num_ports; p++) begin
      if (exp_q[p].size() != 0) begin
        $display("%0d expected flits never left output %s, the oldest is 0x%h",
                 exp_q[p].size(), port_name(p), exp_q[p][0]);
      end
    end
  endtask

  task automatic load_records();
    int                fd;
    int                n;
    string             line;
    string             kind;
    string             pname;
    logic [flit_w-1:0] value;
    fd = $fopen("bench/router_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/router_input.txt");
      end_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      n = $sscanf(line, "%s %s %h", kind, pname, value);
      if (n != 3 || (kind != "S" && kind != "E" && kind != "R" && kind != "M")) begin
        $display("Malformed record in the stimulus file: %s", line);
        end_with_failure();
      end
      if ((kind == "S" || kind == "E") && port_index(pname) < 0) begin
        $display("Unknown port %s in the stimulus file", pname);
        end_with_failure();
      end
      rec_kind.push_back(kind.getc(0));
      rec_port.push_back(port_index(pname));
      rec_value.push_back(value);
    end
    $fclose(fd);
  endtask

  // Runs at the falling edge, where every DUT output is settled
  task automatic monitor_outputs();
    int hit;
    for (int o = 0; o < num_ports; o++) begin
      if (stalled[o]) begin
        compare_value($sformatf("out_send[%s]", port_name(o)), out_send[o], 1'b1);
        compare_value($sformatf("out_data[%s] while stalled", port_name(o)),
                      out_data[o], held_data[o]);
      end
      if (out_send[o] && out_ready[o]) begin
        if (exp_q[o].size() == 0) begin
          $display("Output %s delivered 0x%h where no flit was expected",
                   port_name(o), out_data[o]);
          end_with_failure();
        end
        hit = 0;
        if (search_mode) begin
          // Arbitration order is not fixed, so any pending expectation may match
          hit = -1;
          for (int k = 0; k < exp_q[o].size(); k++) begin
            if (hit < 0 && exp_q[o][k] === out_data[o]) begin
              hit = k;
            end
          end
          if (hit < 0) begin
            hit = 0;
          end
        end
        compare_value($sformatf("out_data[%s]", port_name(o)), out_data[o], exp_q[o][hit]);
        exp_q[o].delete(hit);
      end
      stalled[o] = out_send[o] && !out_ready[o];
      held_data[o] = out_data[o];
    end
  endtask

  // An M record waits for an idle router, so tests do not overlap
  task automatic issue_records();
    logic blocked;
    blocked = 1'b0;
    while (!blocked && rec_next < rec_kind.size()) begin
      case (rec_kind[rec_next])
        "S": send_q[rec_port[rec_next]].push_back(rec_value[rec_next]);
        "E": exp_q[rec_port[rec_next]].push_back(rec_value[rec_next]);
        "R": rand_left = int'(rec_value[rec_next]);
        default: begin
          if (router_idle()) begin
            if (leftover_count() != 0) begin
              report_leftovers();
              end_with_failure();
            end
            search_mode = rec_value[rec_next][0];
          end else begin
            blocked = 1'b1;
          end
        end
      endcase
      if (!blocked) begin
        rec_next++;
      end
    end
  endtask

  task automatic plan_inputs();
    for (int p = 0; p < num_ports; p++) begin
      next_send[p] = 1'b0;
      next_data[p] = in_data[p];
      if (in_send[p]) begin
        // The buffer is empty, so the coming edge takes this flit
        send_q[p].delete(0);
      end else if (send_q[p].size() != 0 && in_ready[p]) begin
        next_send[p] = 1'b1;
        next_data[p] = send_q[p][0];
      end
      if (rand_left > 0) begin
        lfsr = lfsr_step(lfsr);
        next_ready[p] = lfsr[0];
      end else begin
        next_ready[p] = 1'b1;
      end
    end
    if (rand_left > 0) begin
      rand_left--;
    end
  endtask

  task automatic apply_inputs();
    for (int p = 0; p < num_ports; p++) begin
      in_send[p] <= next_send[p];
      in_data[p] <= next_data[p];
      out_ready[p] <= next_ready[p];
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with records or flits still pending", cycle_count);
      end_with_failure();
    end
  end

  initial begin
    for (int p = 0; p < num_ports; p++) begin
      stalled[p] = 1'b0;
      held_data[p] = '0;
    end
    load_records();
    // Each record gets 30 cycles, plus room for reset and the final drain
    cycle_limit = 30 * rec_kind.size() + 100;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    for (int p = 0; p < num_ports; p++) begin
      compare_value($sformatf("in_ready[%s]", port_name(p)), in_ready[p], 1'b1);
      compare_value($sformatf("out_send[%s]", port_name(p)), out_send[p], 1'b0);
    end
    while (rec_next < rec_kind.size() || !router_idle()) begin
      monitor_outputs();
      issue_records();
      plan_inputs();
      @(posedge clk);
      apply_inputs();
      @(negedge clk);
    end
    if (leftover_count() != 0) begin
      report_leftovers();
      $display("Simulation finished: FAIL");
      $fatal(1, "expected flits are missing");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- bench/router_input.txt
# kind port value: S sends the 64-bit hex flit on an input, E expects it on an output
# R drives random out_ready for value cycles, M waits for an idle router, value 1 = any order
# Routing and hop decrement, all from pe
M all 0
S pe 20030102a0000001
E cw 20020102a0000001
S pe 00050304a0000002
E ccw 00040304a0000002
S pe 00200506a0000003
E ns 00100506a0000003
S pe 40400708a0000004
E sn 40300708a0000004
S pe 8a00090aa0000005
E pe 8a00090aa0000005
S pe 60310b0ca0000006
E cw 60300b0ca0000006
S pe 200f1112a0000007
E cw 200e1112a0000007
S pe 5ff01314a0000008
E sn 5fe01314a0000008
S pe a0100f10a0000009
E ns a0000f10a0000009
# Contention, all five inputs eject to pe in the same cycle
M all 1
S cw 0000aa01c0000001
S ccw 0000aa02c0000002
S pe 0000aa03c0000003
S ns 0000aa04c0000004
S sn 0000aa05c0000005
E pe 0000aa01c0000001
E pe 0000aa02c0000002
E pe 0000aa03c0000003
E pe 0000aa04c0000004
E pe 0000aa05c0000005
# Back-pressure, two streams under random out_ready
M all 0
R all c8
S cw 0030cc01d0000001
E ns 0020cc01d0000001
S cw 0030cc01d0000002
E ns 0020cc01d0000002
S cw 0030cc01d0000003
E ns 0020cc01d0000003
S sn 2001dd01d1000001
E cw 2000dd01d1000001
S sn 2001dd01d1000002
E cw 2000dd01d1000002
S sn 2001dd01d1000003
E cw 2000dd01d1000003

//--- sim.f
common/router_pkg.sv
common/port_req_if.sv
hdl/input_port.sv
switch/switch_allocator.sv
switch/output_stage.sv
hdl/router_top.sv
bench/router_tb.sv

//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module router_tb -f sim.f -o router_sim
	./obj_dir/router_sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
